// File: src/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Widths of the machine CSR datapath.
`define CSR_DATA_WIDTH 32
`define CSR_ADDR_WIDTH 12

// Standard machine-mode CSR addresses.
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12

// Read-only identification values, loaded at reset.
`define CSR_MVENDORID_VALUE 32'h7879_7379
`define CSR_MARCHID_VALUE   32'h0150_be98

`endif

// File: src/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // CSR values, also used for program counters.
    typedef logic [`CSR_DATA_WIDTH-1:0] csr_data_t;

    // Encoded as the funct3 field of the CSR instructions.
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

endpackage

// File: src/trap_pkg.sv
`include "csr_config.svh"

package trap_pkg;

    typedef logic [`CSR_DATA_WIDTH-1:0] cause_t;  // Written to MCAUSE as is.

    typedef enum logic [1:0] {
        TRAP_IDLE,
        TRAP_SAVE_EPC,
        TRAP_SAVE_CAUSE,
        TRAP_REDIRECT
    } trap_state_t;

endpackage

// File: src/csr.sv
`include "csr_config.svh"

module csr (
    input  logic               clock,
    input  logic               reset,
    input  logic               csr_we_i,
    input  csr_pkg::csr_addr_t csr_waddr_i,
    input  csr_pkg::csr_addr_t csr_raddr_i,
    input  csr_pkg::csr_data_t csr_wdata_i,
    output csr_pkg::csr_data_t csr_mtvec_o,
    output csr_pkg::csr_data_t csr_mepc_o,
    output csr_pkg::csr_data_t csr_rdata_o
);

    csr_pkg::csr_data_t mstatus_q;
    csr_pkg::csr_data_t mtvec_q;
    csr_pkg::csr_data_t mepc_q;
    csr_pkg::csr_data_t mcause_q;
    csr_pkg::csr_data_t mvendorid_q;
    csr_pkg::csr_data_t marchid_q;

    logic mstatus_we;
    logic mtvec_we;
    logic mepc_we;
    logic mcause_we;

    // Writes to the identification registers or to unknown addresses match no enable.
    assign mstatus_we = csr_we_i && (csr_waddr_i == `CSR_ADDR_MSTATUS);
    assign mtvec_we   = csr_we_i && (csr_waddr_i == `CSR_ADDR_MTVEC);
    assign mepc_we    = csr_we_i && (csr_waddr_i == `CSR_ADDR_MEPC);
    assign mcause_we  = csr_we_i && (csr_waddr_i == `CSR_ADDR_MCAUSE);

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else begin
            if (mstatus_we) begin
                mstatus_q <= csr_wdata_i;  // Plain storage, no interrupt-enable stacking.
            end
            if (mtvec_we) begin
                mtvec_q <= csr_wdata_i;
            end
            if (mepc_we) begin
                mepc_q <= csr_wdata_i;
            end
            if (mcause_we) begin
                mcause_q <= csr_wdata_i;
            end
        end
    end

    // The identification registers only ever take their constants.
    always_ff @(posedge clock) begin
        if (reset) begin
            mvendorid_q <= `CSR_MVENDORID_VALUE;
            marchid_q   <= `CSR_MARCHID_VALUE;
        end
    end

    always_comb begin
        case (csr_raddr_i)
            `CSR_ADDR_MSTATUS:   csr_rdata_o = mstatus_q;
            `CSR_ADDR_MTVEC:     csr_rdata_o = mtvec_q;
            `CSR_ADDR_MEPC:      csr_rdata_o = mepc_q;
            `CSR_ADDR_MCAUSE:    csr_rdata_o = mcause_q;
            `CSR_ADDR_MVENDORID: csr_rdata_o = mvendorid_q;
            `CSR_ADDR_MARCHID:   csr_rdata_o = marchid_q;
            default:             csr_rdata_o = '0;
        endcase
    end

    // Direct taps for the trap unit.
    assign csr_mtvec_o = mtvec_q;
    assign csr_mepc_o  = mepc_q;

endmodule

// File: src/csr_op_unit.sv
module csr_op_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               op_valid_i,
    input  csr_pkg::csr_op_t   op_kind_i,
    input  csr_pkg::csr_addr_t op_addr_i,
    input  csr_pkg::csr_data_t op_operand_i,
    output csr_pkg::csr_addr_t csr_raddr_o,
    input  csr_pkg::csr_data_t csr_rdata_i,
    output logic               req_o,
    output csr_pkg::csr_addr_t waddr_o,
    output csr_pkg::csr_data_t wdata_o,
    input  logic               gnt_i,
    output logic               busy_o,
    output logic               done_o,
    output csr_pkg::csr_data_t rd_data_o
);

    logic               busy_q;
    logic               req_q;
    logic               done_q;
    csr_pkg::csr_op_t   kind_q;
    csr_pkg::csr_addr_t addr_q;
    csr_pkg::csr_data_t operand_q;
    csr_pkg::csr_data_t old_q;
    logic               accept;
    logic               skip_write;

    function automatic csr_pkg::csr_data_t modify(input csr_pkg::csr_op_t kind,
                                                  input csr_pkg::csr_data_t old,
                                                  input csr_pkg::csr_data_t operand);
        csr_pkg::csr_data_t result;
        case (kind)
            csr_pkg::CSR_RS: result = old | operand;
            csr_pkg::CSR_RC: result = old & ~operand;
            default:         result = operand;
        endcase
        return result;
    endfunction

    assign accept     = op_valid_i && !busy_q;
    assign skip_write = (op_kind_i != csr_pkg::CSR_RW) && (op_operand_i == '0);

    // While busy the read port stays on the latched address.
    assign csr_raddr_o = busy_q ? addr_q : op_addr_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= 1'b0;
            req_q  <= 1'b0;
            done_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
            req_q  <= !skip_write;
            done_q <= skip_write;
        end else if (req_q && gnt_i) begin
            req_q  <= 1'b0;
            done_q <= 1'b1;
        end else if (done_q) begin
            done_q <= 1'b0;
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            kind_q    <= op_kind_i;
            addr_q    <= op_addr_i;
            operand_q <= op_operand_i;
            old_q     <= csr_rdata_i;
        end else if (req_q && gnt_i) begin
            old_q <= csr_rdata_i;  // Picks up any trap write made while waiting.
        end
    end

    // The new value follows the live read, so a trap write that won the port comes first.
    assign req_o     = req_q;
    assign waddr_o   = addr_q;
    assign wdata_o   = modify(kind_q, csr_rdata_i, operand_q);
    assign busy_o    = busy_q;
    assign done_o    = done_q;
    assign rd_data_o = old_q;

endmodule

// File: src/trap_unit.sv
`include "csr_config.svh"

module trap_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               exception_i,
    input  trap_pkg::cause_t   cause_i,
    input  csr_pkg::csr_data_t epc_i,
    input  logic               mret_i,
    input  csr_pkg::csr_data_t csr_mtvec_i,
    input  csr_pkg::csr_data_t csr_mepc_i,
    output logic               req_o,
    output csr_pkg::csr_addr_t waddr_o,
    output csr_pkg::csr_data_t wdata_o,
    input  logic               gnt_i,
    output logic               redirect_o,
    output csr_pkg::csr_data_t redirect_pc_o
);

    trap_pkg::trap_state_t state_q;
    trap_pkg::cause_t      cause_q;
    csr_pkg::csr_data_t    epc_q;
    csr_pkg::csr_data_t    target_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= trap_pkg::TRAP_IDLE;
        end else begin
            case (state_q)
                trap_pkg::TRAP_IDLE: begin
                    if (exception_i) begin
                        state_q <= trap_pkg::TRAP_SAVE_EPC;
                    end else if (mret_i) begin
                        state_q <= trap_pkg::TRAP_REDIRECT;
                    end
                end
                trap_pkg::TRAP_SAVE_EPC: begin
                    if (gnt_i) begin
                        state_q <= trap_pkg::TRAP_SAVE_CAUSE;
                    end
                end
                trap_pkg::TRAP_SAVE_CAUSE: begin
                    if (gnt_i) begin
                        state_q <= trap_pkg::TRAP_REDIRECT;
                    end
                end
                default: state_q <= trap_pkg::TRAP_IDLE;  // Redirect lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == trap_pkg::TRAP_IDLE) begin
            if (exception_i) begin
                cause_q <= cause_i;
                epc_q   <= epc_i;
            end else if (mret_i) begin
                target_q <= csr_mepc_i;
            end
        end else if (state_q == trap_pkg::TRAP_SAVE_CAUSE && gnt_i) begin
            target_q <= csr_mtvec_i;
        end
    end

    assign req_o = (state_q == trap_pkg::TRAP_SAVE_EPC) ||
                   (state_q == trap_pkg::TRAP_SAVE_CAUSE);

    always_comb begin
        if (state_q == trap_pkg::TRAP_SAVE_CAUSE) begin
            waddr_o = `CSR_ADDR_MCAUSE;
            wdata_o = cause_q;
        end else begin
            waddr_o = `CSR_ADDR_MEPC;
            wdata_o = epc_q;
        end
    end

    assign redirect_o    = (state_q == trap_pkg::TRAP_REDIRECT);
    assign redirect_pc_o = target_q;

endmodule

// File: src/csr_write_arbiter.sv
module csr_write_arbiter (
    input  logic               trap_req_i,
    input  csr_pkg::csr_addr_t trap_addr_i,
    input  csr_pkg::csr_data_t trap_data_i,
    input  logic               op_req_i,
    input  csr_pkg::csr_addr_t op_addr_i,
    input  csr_pkg::csr_data_t op_data_i,
    output logic               csr_we_o,
    output csr_pkg::csr_addr_t csr_waddr_o,
    output csr_pkg::csr_data_t csr_wdata_o,
    output logic               trap_gnt_o,
    output logic               op_gnt_o
);

    // The trap unit always wins.
    assign trap_gnt_o = trap_req_i;
    assign op_gnt_o   = op_req_i && !trap_req_i;

    assign csr_we_o = trap_req_i || op_req_i;

    always_comb begin
        if (trap_req_i) begin
            csr_waddr_o = trap_addr_i;
            csr_wdata_o = trap_data_i;
        end else begin
            csr_waddr_o = op_addr_i;
            csr_wdata_o = op_data_i;
        end
    end

endmodule

// File: src/csr_subsystem.sv
module csr_subsystem (
    input  logic               clock,
    input  logic               reset,
    input  logic               op_valid_i,
    input  csr_pkg::csr_op_t   op_kind_i,
    input  csr_pkg::csr_addr_t op_addr_i,
    input  csr_pkg::csr_data_t op_operand_i,
    output logic               busy_o,
    output logic               done_o,
    output csr_pkg::csr_data_t rd_data_o,
    input  logic               exception_i,
    input  trap_pkg::cause_t   cause_i,
    input  csr_pkg::csr_data_t epc_i,
    input  logic               mret_i,
    output logic               redirect_o,
    output csr_pkg::csr_data_t redirect_pc_o
);

    logic               csr_we;
    csr_pkg::csr_addr_t csr_waddr;
    csr_pkg::csr_data_t csr_wdata;
    csr_pkg::csr_addr_t csr_raddr;
    csr_pkg::csr_data_t csr_rdata;
    csr_pkg::csr_data_t csr_mtvec;
    csr_pkg::csr_data_t csr_mepc;

    logic               trap_req;
    csr_pkg::csr_addr_t trap_addr;
    csr_pkg::csr_data_t trap_data;
    logic               trap_gnt;
    logic               op_req;
    csr_pkg::csr_addr_t op_addr;
    csr_pkg::csr_data_t op_data;
    logic               op_gnt;

    csr csr0 (
        .clock       (clock),
        .reset       (reset),
        .csr_we_i    (csr_we),
        .csr_waddr_i (csr_waddr),
        .csr_raddr_i (csr_raddr),
        .csr_wdata_i (csr_wdata),
        .csr_mtvec_o (csr_mtvec),
        .csr_mepc_o  (csr_mepc),
        .csr_rdata_o (csr_rdata)
    );

    csr_write_arbiter arbiter0 (
        .trap_req_i  (trap_req),
        .trap_addr_i (trap_addr),
        .trap_data_i (trap_data),
        .op_req_i    (op_req),
        .op_addr_i   (op_addr),
        .op_data_i   (op_data),
        .csr_we_o    (csr_we),
        .csr_waddr_o (csr_waddr),
        .csr_wdata_o (csr_wdata),
        .trap_gnt_o  (trap_gnt),
        .op_gnt_o    (op_gnt)
    );

    csr_op_unit op_unit0 (
        .clock        (clock),
        .reset        (reset),
        .op_valid_i   (op_valid_i),
        .op_kind_i    (op_kind_i),
        .op_addr_i    (op_addr_i),
        .op_operand_i (op_operand_i),
        .csr_raddr_o  (csr_raddr),
        .csr_rdata_i  (csr_rdata),
        .req_o        (op_req),
        .waddr_o      (op_addr),
        .wdata_o      (op_data),
        .gnt_i        (op_gnt),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .rd_data_o    (rd_data_o)
    );

    trap_unit trap_unit0 (
        .clock         (clock),
        .reset         (reset),
        .exception_i   (exception_i),
        .cause_i       (cause_i),
        .epc_i         (epc_i),
        .mret_i        (mret_i),
        .csr_mtvec_i   (csr_mtvec),
        .csr_mepc_i    (csr_mepc),
        .req_o         (trap_req),
        .waddr_o       (trap_addr),
        .wdata_o       (trap_data),
        .gnt_i         (trap_gnt),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// File: testbench/csr_subsystem_properties.sv
module csr_subsystem_properties (
    input logic clock,
    input logic reset,
    input logic trap_req_i,
    input logic op_req_i,
    input logic trap_gnt_i,
    input logic op_gnt_i,
    input logic csr_we_i,
    input logic exception_i,
    input logic redirect_i,
    input logic done_i
);

    grants_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(trap_gnt_i && op_gnt_i))
        else $error("Trap and operation grants are high together.");

    write_needs_request: assert property (@(posedge clock) disable iff (reset)
        csr_we_i |-> (trap_req_i || op_req_i))
        else $error("CSR write enable is high with no request.");

    // The trap unit owns the port, so MEPC, MCAUSE and the redirect take one cycle each.
    redirect_latency: assert property (@(posedge clock) disable iff (reset)
        exception_i |-> ##3 redirect_i)
        else $error("redirect_o did not follow exception_i by three cycles.");

    done_low_in_reset: assert property (@(posedge clock)
        reset |=> !done_i)
        else $error("done_o is high while in reset.");

endmodule

bind csr_subsystem csr_subsystem_properties props0 (
    .clock       (clock),
    .reset       (reset),
    .trap_req_i  (trap_req),
    .op_req_i    (op_req),
    .trap_gnt_i  (trap_gnt),
    .op_gnt_i    (op_gnt),
    .csr_we_i    (csr_we),
    .exception_i (exception_i),
    .redirect_i  (redirect_o),
    .done_i      (done_o)
);

// File: testbench/csr_subsystem_tb.sv
module csr_subsystem_tb;

    localparam int CLOCK_PERIOD = 40;
    localparam int WAIT_LIMIT   = 16;  // Cycles allowed for one done_o or redirect_o.

    logic               clock;
    logic               reset;
    logic               op_valid;
    csr_pkg::csr_op_t   op_kind;
    csr_pkg::csr_addr_t op_addr;
    csr_pkg::csr_data_t op_operand;
    logic               busy;
    logic               done;
    csr_pkg::csr_data_t rd_data;
    logic               exception;
    trap_pkg::cause_t   cause;
    csr_pkg::csr_data_t epc;
    logic               mret;
    logic               redirect;
    csr_pkg::csr_data_t redirect_pc;

    int trace_lines = 0;

    csr_subsystem dut0 (
        .clock         (clock),
        .reset         (reset),
        .op_valid_i    (op_valid),
        .op_kind_i     (op_kind),
        .op_addr_i     (op_addr),
        .op_operand_i  (op_operand),
        .busy_o        (busy),
        .done_o        (done),
        .rd_data_o     (rd_data),
        .exception_i   (exception),
        .cause_i       (cause),
        .epc_i         (epc),
        .mret_i        (mret),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input csr_pkg::csr_data_t actual,
                               input csr_pkg::csr_data_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at time %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic wait_drive_point();
        @(posedge clock);
        #2;
    endtask

    // Raises the selected pulses for exactly one cycle, starting at a drive point.
    task automatic pulse_inputs(input logic do_op, input logic do_exc, input logic do_mret);
        op_valid  = do_op;
        exception = do_exc;
        mret      = do_mret;
        @(posedge clock);
        #2;
        op_valid  = 1'b0;
        exception = 1'b0;
        mret      = 1'b0;
    endtask

    // Outputs are sampled on the falling edge, well away from the drive point.
    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!done) begin
            check_value("busy_o", busy, 1'b1);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("The operation unit never raised done_o.");
            end
            @(negedge clock);
        end
        check_value("busy_o", busy, 1'b1);  // Busy covers the done cycle too.
        @(negedge clock);
        check_value("done_o", done, 1'b0);
        check_value("busy_o", busy, 1'b0);
    endtask

    task automatic wait_for_redirect();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!redirect) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("The trap unit never raised redirect_o.");
            end
            @(negedge clock);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       cmd;
        string       rest;
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] operand;
        logic [31:0] exp_old;
        logic [31:0] exc_cause;
        logic [31:0] exc_epc;
        logic [31:0] exp_target;
        clock      = 1'b0;
        reset      = 1'b1;
        op_valid   = 1'b0;
        op_kind    = csr_pkg::CSR_RW;
        op_addr    = '0;
        op_operand = '0;
        exception  = 1'b0;
        cause      = '0;
        epc        = '0;
        mret       = 1'b0;
        fd = $fopen("testbench/csr_trace.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file testbench/csr_trace.txt.");
        end
        while ($fgets(rest, fd) != 0) begin
            trace_lines++;
        end
        $fclose(fd);
        fd = $fopen("testbench/csr_trace.txt", "r");
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(rest, fd);  // Comment line.
            end else if (cmd == "OP" || cmd == "BOTH") begin
                code = $fscanf(fd, "%h %h %h %h", kind, addr, operand, exp_old);
                if (code != 4) begin
                    abort_run({"A trace line has too few fields after ", cmd});
                end
                if (cmd == "BOTH") begin
                    code = $fscanf(fd, "%h %h %h", exc_cause, exc_epc, exp_target);
                    if (code != 3) begin
                        abort_run("A BOTH line in the trace has too few trap fields.");
                    end
                end
                wait_drive_point();
                op_kind    = csr_pkg::csr_op_t'(kind[1:0]);
                op_addr    = addr[11:0];
                op_operand = operand;
                if (cmd == "BOTH") begin
                    cause = exc_cause;
                    epc   = exc_epc;
                    pulse_inputs(1'b1, 1'b1, 1'b0);
                    wait_for_redirect();
                    check_value("redirect_pc_o", redirect_pc, exp_target);
                end else begin
                    pulse_inputs(1'b1, 1'b0, 1'b0);
                end
                wait_for_done();
                check_value("rd_data_o", rd_data, exp_old);
            end else if (cmd == "EXC") begin
                code = $fscanf(fd, "%h %h %h", exc_cause, exc_epc, exp_target);
                if (code != 3) begin
                    abort_run("An EXC line in the trace has too few fields.");
                end
                wait_drive_point();
                cause = exc_cause;
                epc   = exc_epc;
                pulse_inputs(1'b0, 1'b1, 1'b0);
                wait_for_redirect();
                check_value("redirect_pc_o", redirect_pc, exp_target);
            end else if (cmd == "MRET") begin
                code = $fscanf(fd, "%h", exp_target);
                if (code != 1) begin
                    abort_run("An MRET line in the trace has no expected target.");
                end
                wait_drive_point();
                pulse_inputs(1'b0, 1'b0, 1'b1);
                wait_for_redirect();
                check_value("redirect_pc_o", redirect_pc, exp_target);
            end else begin
                abort_run({"Unknown command in the trace file: ", cmd});
            end
        end
        $fclose(fd);
        $display("Result: PASSED");
        $finish;
    end

    // Budget of 20 cycles per trace line.
    initial begin
        @(negedge reset);
        #(trace_lines * 20 * CLOCK_PERIOD);
        abort_run("The watchdog expired before the trace was finished.");
    end

endmodule

// File: testbench/csr_trace.txt
# OP kind(1=rw 2=rs 3=rc) addr operand expected_old | EXC cause epc expected_target
# MRET expected_target | BOTH kind addr operand expected_old cause epc expected_target
OP 1 300 00001888 00000000
OP 1 300 00000008 00001888
OP 1 305 80000100 00000000
OP 1 305 80000100 80000100
OP 1 341 00000040 00000000
OP 2 341 00000000 00000040
OP 1 342 0000000b 00000000
OP 2 342 00000000 0000000b
OP 2 300 000000f0 00000008
OP 3 300 00000018 000000f8
OP 2 300 00000000 000000e0
OP 3 300 00000000 000000e0
OP 1 f11 12345678 78797379
OP 2 f11 00000000 78797379
OP 1 f12 ffffffff 0150be98
OP 2 f12 00000000 0150be98
OP 1 7c0 deadbeef 00000000
OP 2 7c0 00000000 00000000
EXC 00000002 00001004 80000100
OP 2 341 00000000 00001004
OP 2 342 00000000 00000002
MRET 00001004
OP 1 341 00002000 00001004
MRET 00002000
BOTH 2 341 00000001 00003000 00000007 00003000 80000100
OP 2 341 00000000 00003001
OP 2 342 00000000 00000007
MRET 00003001
BOTH 3 342 00000003 0000000b 0000000b 00004000 80000100
OP 2 342 00000000 00000008
OP 1 305 00000200 80000100
EXC 0000000d 00005000 00000200
OP 2 341 00000000 00005000

// File: compile.f
+incdir+src
src/csr_pkg.sv
src/trap_pkg.sv
src/csr.sv
src/csr_op_unit.sv
src/trap_unit.sv
src/csr_write_arbiter.sv
src/csr_subsystem.sv
testbench/csr_subsystem_properties.sv
testbench/csr_subsystem_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = csr_subsystem_tb
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
